// ==== design/rv32i_alu.sv ====
module rv32i_alu import rv32i_pkg::*; (
  input  logic [XLEN-1:0] i_a,
  input  logic [XLEN-1:0] i_b,
  input  alu_op_t         i_op,
  output logic [XLEN-1:0] o_result,
  output logic            o_zero,
  output logic            o_less
);

  logic [XLEN-1:0] diff;
  logic            ovf;

  assign diff = i_a - i_b;
  // Signed overflow of a - b
  assign ovf  = (i_a[XLEN-1] != i_b[XLEN-1]) && (diff[XLEN-1] != i_a[XLEN-1]);

  always_comb
  begin
    case (i_op)
      ALU_SUB: o_result = diff;
      ALU_AND: o_result = i_a & i_b;
      ALU_OR:  o_result = i_a | i_b;
      ALU_XOR: o_result = i_a ^ i_b;
      ALU_SLL: o_result = i_a << i_b[$clog2(XLEN)-1:0];
      default: o_result = i_a + i_b;
    endcase
  end

  assign o_zero = (o_result == '0);
  assign o_less = diff[XLEN-1] ^ ovf;  // Sign corrected for overflow

endmodule

// ==== design/rv32i_cpu.sv ====
module rv32i_cpu import rv32i_pkg::*; (
  input  logic            clk,
  input  logic            reset,
  output logic [XLEN-1:0] o_pc,
  input  logic [XLEN-1:0] i_inst,
  output logic            o_mem_we,
  output logic [XLEN-1:0] o_mem_addr,
  output logic [XLEN-1:0] o_mem_wdata,
  input  logic [XLEN-1:0] i_mem_rdata
);

  logic [XLEN-1:0] pc;
  logic [XLEN-1:0] if_id_pc;
  inst_u           if_id_inst;
  id_ex_t          id_ex;
  ex_mem_t         ex_mem;
  mem_wb_t         mem_wb;
  ctrl_t           dec_ctrl;
  alu_op_t         dec_alu_op;
  logic [XLEN-1:0] dec_imm;
  logic [XLEN-1:0] rs1_data;
  logic [XLEN-1:0] rs2_data;
  logic            stall;
  logic            flush;
  fwd_sel_t        fwd_a;
  fwd_sel_t        fwd_b;
  logic [XLEN-1:0] src_a;
  logic [XLEN-1:0] src_b;
  logic [XLEN-1:0] alu_result;
  logic            alu_zero;
  logic            alu_less;
  logic            br_cond;
  logic            redirect;
  logic [XLEN-1:0] target;
  logic [XLEN-1:0] wb_data;

  function automatic logic [XLEN-1:0] fwd_mux(input fwd_sel_t sel,
                                               input logic [XLEN-1:0] reg_val);
    case (sel)
      FWD_EX_MEM: return ex_mem.alu_out;
      FWD_MEM_WB: return wb_data;
      default:    return reg_val;
    endcase
  endfunction

  // Fetch
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      pc <= '0;
    else if (redirect)
      pc <= target;  // Redirect beats a stall
    else if (!stall)
      pc <= pc + XLEN'(PC_STEP);
  end

  assign o_pc = pc;

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset || flush)
    begin
      if_id_pc   <= '0;
      if_id_inst <= '0;  // Opcode zero decodes to no control
    end
    else if (!stall)
    begin
      if_id_pc   <= pc;
      if_id_inst <= i_inst;
    end
  end

  // Decode
  rv32i_decoder u_decoder (
    .i_inst   (if_id_inst),
    .o_ctrl   (dec_ctrl),
    .o_alu_op (dec_alu_op)
  );

  rv32i_regfile u_regfile (
    .clk      (clk),
    .i_we     (mem_wb.ctrl.reg_write),
    .i_waddr  (mem_wb.rd),
    .i_raddr1 (if_id_inst.r_fmt.rs1),
    .i_raddr2 (if_id_inst.r_fmt.rs2),
    .i_wdata  (wb_data),
    .o_rdata1 (rs1_data),
    .o_rdata2 (rs2_data)
  );

  // One immediate per instruction, picked by format
  always_comb
  begin
    if (dec_ctrl.store_imm)
      dec_imm = {{(XLEN-12){if_id_inst.s_fmt.imm_11_5[6]}},
                 if_id_inst.s_fmt.imm_11_5, if_id_inst.s_fmt.imm_4_0};
    else if (dec_ctrl.alu_imm)
      dec_imm = {{(XLEN-12){if_id_inst.i_fmt.imm_11_0[11]}}, if_id_inst.i_fmt.imm_11_0};
    else if (dec_ctrl.jal)
      dec_imm = {{(XLEN-21){if_id_inst.j_fmt.imm_20}}, if_id_inst.j_fmt.imm_20,
                 if_id_inst.j_fmt.imm_19_12, if_id_inst.j_fmt.imm_11,
                 if_id_inst.j_fmt.imm_10_1, 1'b0};
    else
      dec_imm = {{(XLEN-13){if_id_inst.b_fmt.imm_12}}, if_id_inst.b_fmt.imm_12,
                 if_id_inst.b_fmt.imm_11, if_id_inst.b_fmt.imm_10_5,
                 if_id_inst.b_fmt.imm_4_1, 1'b0};
  end

  rv32i_hazard_unit u_hazard (
    .i_rs1       (if_id_inst.r_fmt.rs1),
    .i_rs2       (if_id_inst.r_fmt.rs2),
    .i_id_ex     (id_ex),
    .i_ex_mem_rd (ex_mem.rd),
    .i_mem_wb_rd (mem_wb.rd),
    .i_ex_mem_wr (ex_mem.ctrl.reg_write),
    .i_mem_wb_wr (mem_wb.ctrl.reg_write),
    .i_redirect  (redirect),
    .o_stall     (stall),
    .o_flush     (flush),
    .o_fwd_a     (fwd_a),
    .o_fwd_b     (fwd_b)
  );

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset || flush || stall)
      id_ex <= '0;  // Bubble
    else
      id_ex <= '{pc: if_id_pc, ctrl: dec_ctrl, alu_op: dec_alu_op,
                 funct3: if_id_inst.r_fmt.funct3, rs1: if_id_inst.r_fmt.rs1,
                 rs2: if_id_inst.r_fmt.rs2, rd: if_id_inst.r_fmt.rd,
                 rs1_data: rs1_data, rs2_data: rs2_data, imm: dec_imm};
  end

  // Execute
  always_comb
  begin
    src_a = fwd_mux(fwd_a, id_ex.rs1_data);
    src_b = fwd_mux(fwd_b, id_ex.rs2_data);
  end

  rv32i_alu u_alu (
    .i_a      (src_a),
    .i_b      (id_ex.ctrl.alu_imm ? id_ex.imm : src_b),
    .i_op     (id_ex.alu_op),
    .o_result (alu_result),
    .o_zero   (alu_zero),
    .o_less   (alu_less)
  );

  always_comb
  begin
    case (id_ex.funct3)
      F3_BEQ:  br_cond = alu_zero;
      F3_BNE:  br_cond = !alu_zero;
      F3_BLT:  br_cond = alu_less;
      F3_BGE:  br_cond = !alu_less;
      default: br_cond = 1'b0;
    endcase
  end

  assign redirect = (id_ex.ctrl.branch && br_cond) || id_ex.ctrl.jal;
  assign target   = id_ex.pc + id_ex.imm;  // Branch and jal share the adder

  // Memory and writeback registers
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      ex_mem <= '0;
      mem_wb <= '0;
    end
    else
    begin
      ex_mem <= '{pc: id_ex.pc, ctrl: id_ex.ctrl, rd: id_ex.rd,
                  alu_out: alu_result, store_data: src_b};
      mem_wb <= '{pc: ex_mem.pc, ctrl: ex_mem.ctrl, rd: ex_mem.rd,
                  alu_out: ex_mem.alu_out, load_data: i_mem_rdata};
    end
  end

  assign o_mem_we    = ex_mem.ctrl.mem_write;
  assign o_mem_addr  = ex_mem.alu_out;
  assign o_mem_wdata = ex_mem.store_data;

  always_comb
  begin
    if (mem_wb.ctrl.jal)
      wb_data = mem_wb.pc + XLEN'(PC_STEP);  // Link value
    else if (mem_wb.ctrl.mem_to_reg)
      wb_data = mem_wb.load_data;
    else
      wb_data = mem_wb.alu_out;
  end

  // Both wrong-path slots reach memory as bubbles
  a_redirect_flush: assert property (@(posedge clk) disable iff (reset)
    redirect |-> ##2 (ex_mem.ctrl == '0) ##1 (ex_mem.ctrl == '0))
    else $error("wrong-path instruction survived a redirect");

  // Load data is only forwarded once it sits in MEM/WB
  a_no_load_fwd: assert property (@(posedge clk) disable iff (reset)
    ex_mem.ctrl.mem_to_reg |-> (fwd_a != FWD_EX_MEM && fwd_b != FWD_EX_MEM))
    else $error("load result forwarded from EX/MEM");

endmodule

// ==== design/rv32i_decoder.sv ====
module rv32i_decoder import rv32i_pkg::*; (
  input  inst_u   i_inst,
  output ctrl_t   o_ctrl,
  output alu_op_t o_alu_op
);

  always_comb
  begin
    o_ctrl = '0;
    case (i_inst.r_fmt.opcode)
      OP_R: o_ctrl.reg_write = 1'b1;
      OP_I_ARITH:
      begin
        o_ctrl.reg_write = 1'b1;
        o_ctrl.alu_imm   = 1'b1;
      end
      OP_LOAD:
      begin
        o_ctrl.reg_write  = 1'b1;
        o_ctrl.mem_to_reg = 1'b1;
        o_ctrl.alu_imm    = 1'b1;  // Address is rs1 + imm
      end
      OP_STORE:
      begin
        o_ctrl.mem_write = 1'b1;
        o_ctrl.alu_imm   = 1'b1;
        o_ctrl.store_imm = 1'b1;
      end
      OP_BRANCH: o_ctrl.branch = 1'b1;
      OP_JAL:
      begin
        o_ctrl.reg_write = 1'b1;  // Link register
        o_ctrl.jal       = 1'b1;
      end
      default: o_ctrl = '0;
    endcase
  end

  always_comb
  begin
    o_alu_op = ALU_ADD;
    if (i_inst.r_fmt.opcode == OP_R || i_inst.r_fmt.opcode == OP_I_ARITH)
    begin
      case (i_inst.r_fmt.funct3)
        // funct7 only means subtract in the register form
        F3_ADD: o_alu_op = (i_inst.r_fmt.opcode == OP_R && i_inst.r_fmt.funct7[5]) ?
                           ALU_SUB : ALU_ADD;
        F3_SLL: o_alu_op = ALU_SLL;
        F3_XOR: o_alu_op = ALU_XOR;
        F3_OR:  o_alu_op = ALU_OR;
        F3_AND: o_alu_op = ALU_AND;
        default: o_alu_op = ALU_ADD;
      endcase
    end
    else if (i_inst.r_fmt.opcode == OP_BRANCH)
      o_alu_op = ALU_SUB;  // Compare by subtraction
  end

  // Only add/sub encodings of funct7 are supported
  always_comb
  begin
    if (i_inst.r_fmt.opcode == OP_R)
      assert (i_inst.r_fmt.funct7 == 7'b0 || i_inst.r_fmt.funct7 == F7_SUB)
        else $error("unsupported funct7 %b on R-type", i_inst.r_fmt.funct7);
  end

endmodule

// ==== design/rv32i_hazard_unit.sv ====
module rv32i_hazard_unit import rv32i_pkg::*; (
  input  logic [REG_AW-1:0] i_rs1,
  input  logic [REG_AW-1:0] i_rs2,
  input  id_ex_t            i_id_ex,
  input  logic [REG_AW-1:0] i_ex_mem_rd,
  input  logic [REG_AW-1:0] i_mem_wb_rd,
  input  logic              i_ex_mem_wr,
  input  logic              i_mem_wb_wr,
  input  logic              i_redirect,
  output logic              o_stall,
  output logic              o_flush,
  output fwd_sel_t          o_fwd_a,
  output fwd_sel_t          o_fwd_b
);

  logic load_in_ex;

  // Youngest producer has priority
  function automatic fwd_sel_t pick(input logic [REG_AW-1:0] src);
    if (i_ex_mem_wr && i_ex_mem_rd != '0 && i_ex_mem_rd == src)
      return FWD_EX_MEM;
    if (i_mem_wb_wr && i_mem_wb_rd != '0 && i_mem_wb_rd == src)
      return FWD_MEM_WB;
    return FWD_NONE;
  endfunction

  assign load_in_ex = i_id_ex.ctrl.mem_to_reg && (i_id_ex.rd != '0);
  assign o_stall    = load_in_ex && (i_id_ex.rd == i_rs1 || i_id_ex.rd == i_rs2);
  assign o_flush    = i_redirect;

  always_comb
  begin
    o_fwd_a = pick(i_id_ex.rs1);
    o_fwd_b = pick(i_id_ex.rs2);
  end

  always_comb
  begin
    // A load and a redirect never sit in execute together
    assert (!(o_stall && o_flush))
      else $error("stall and flush raised in the same cycle");
  end

endmodule

// ==== design/rv32i_pkg.sv ====
package rv32i_pkg;

  localparam int XLEN    = 32;
  localparam int REG_AW  = 5;
  localparam int PC_STEP = 4;

  // Major opcodes
  localparam logic [6:0] OP_R       = 7'b0110011;
  localparam logic [6:0] OP_I_ARITH = 7'b0010011;
  localparam logic [6:0] OP_LOAD    = 7'b0000011;
  localparam logic [6:0] OP_STORE   = 7'b0100011;
  localparam logic [6:0] OP_BRANCH  = 7'b1100011;
  localparam logic [6:0] OP_JAL     = 7'b1101111;

  // Branch conditions
  localparam logic [2:0] F3_BEQ = 3'b000;
  localparam logic [2:0] F3_BNE = 3'b001;
  localparam logic [2:0] F3_BLT = 3'b100;
  localparam logic [2:0] F3_BGE = 3'b101;

  // Arithmetic funct3, shared by register and immediate forms
  localparam logic [2:0] F3_ADD = 3'b000;
  localparam logic [2:0] F3_SLL = 3'b001;
  localparam logic [2:0] F3_XOR = 3'b100;
  localparam logic [2:0] F3_OR  = 3'b110;
  localparam logic [2:0] F3_AND = 3'b111;
  localparam logic [6:0] F7_SUB = 7'b0100000;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLL
  } alu_op_t;

  typedef enum logic [1:0] {
    FWD_NONE,
    FWD_EX_MEM,
    FWD_MEM_WB
  } fwd_sel_t;

  typedef struct packed {
    logic [6:0]        funct7;
    logic [REG_AW-1:0] rs2;
    logic [REG_AW-1:0] rs1;
    logic [2:0]        funct3;
    logic [REG_AW-1:0] rd;
    logic [6:0]        opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0]       imm_11_0;
    logic [REG_AW-1:0] rs1;
    logic [2:0]        funct3;
    logic [REG_AW-1:0] rd;
    logic [6:0]        opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0]        imm_11_5;
    logic [REG_AW-1:0] rs2;
    logic [REG_AW-1:0] rs1;
    logic [2:0]        funct3;
    logic [4:0]        imm_4_0;
    logic [6:0]        opcode;
  } s_fmt_t;

  typedef struct packed {
    logic              imm_12;
    logic [5:0]        imm_10_5;
    logic [REG_AW-1:0] rs2;
    logic [REG_AW-1:0] rs1;
    logic [2:0]        funct3;
    logic [3:0]        imm_4_1;
    logic              imm_11;
    logic [6:0]        opcode;
  } b_fmt_t;

  typedef struct packed {
    logic              imm_20;
    logic [9:0]        imm_10_1;
    logic              imm_11;
    logic [7:0]        imm_19_12;
    logic [REG_AW-1:0] rd;
    logic [6:0]        opcode;
  } j_fmt_t;

  // One instruction word, five field layouts
  typedef union packed {
    r_fmt_t r_fmt;
    i_fmt_t i_fmt;
    s_fmt_t s_fmt;
    b_fmt_t b_fmt;
    j_fmt_t j_fmt;
  } inst_u;

  typedef struct packed {
    logic reg_write;
    logic mem_to_reg;
    logic mem_write;
    logic alu_imm;    // Operand B from imm
    logic store_imm;  // S-type immediate layout
    logic branch;
    logic jal;
  } ctrl_t;

  typedef struct packed {
    logic [XLEN-1:0]   pc;
    ctrl_t             ctrl;
    alu_op_t           alu_op;
    logic [2:0]        funct3;
    logic [REG_AW-1:0] rs1;
    logic [REG_AW-1:0] rs2;
    logic [REG_AW-1:0] rd;
    logic [XLEN-1:0]   rs1_data;
    logic [XLEN-1:0]   rs2_data;
    logic [XLEN-1:0]   imm;
  } id_ex_t;

  typedef struct packed {
    logic [XLEN-1:0]   pc;
    ctrl_t             ctrl;
    logic [REG_AW-1:0] rd;
    logic [XLEN-1:0]   alu_out;
    logic [XLEN-1:0]   store_data;
  } ex_mem_t;

  typedef struct packed {
    logic [XLEN-1:0]   pc;
    ctrl_t             ctrl;
    logic [REG_AW-1:0] rd;
    logic [XLEN-1:0]   alu_out;
    logic [XLEN-1:0]   load_data;
  } mem_wb_t;

endpackage

// ==== design/rv32i_regfile.sv ====
module rv32i_regfile import rv32i_pkg::*; (
  input  logic              clk,
  input  logic              i_we,
  input  logic [REG_AW-1:0] i_waddr,
  input  logic [REG_AW-1:0] i_raddr1,
  input  logic [REG_AW-1:0] i_raddr2,
  input  logic [XLEN-1:0]   i_wdata,
  output logic [XLEN-1:0]   o_rdata1,
  output logic [XLEN-1:0]   o_rdata2
);

  logic [XLEN-1:0] regs [1:31];  // x0 has no storage

  // Writeback in the same cycle wins over stored value
  function automatic logic [XLEN-1:0] read_port(input logic [REG_AW-1:0] addr);
    if (addr == '0)
      return '0;
    if (i_we && addr == i_waddr)
      return i_wdata;
    return regs[addr];
  endfunction

  always_ff @(posedge clk)
  begin
    if (i_we && i_waddr != '0)
      regs[i_waddr] <= i_wdata;
  end

  always_comb
  begin
    o_rdata1 = read_port(i_raddr1);
    o_rdata2 = read_port(i_raddr2);
  end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the core testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -j 0 -f rv32i_cpu.f \
  --top-module rv32i_cpu_tb -o rv32i_cpu_sim
./obj_dir/rv32i_cpu_sim | tee sim.log
if grep -q "tests failed" sim.log; then
  echo "Simulation failed, see sim.log"
  exit 1
fi
grep -q "all tests passed" sim.log
echo "Simulation passed"

// ==== rv32i_cpu.f ====
design/rv32i_pkg.sv
design/rv32i_decoder.sv
design/rv32i_regfile.sv
design/rv32i_alu.sv
design/rv32i_hazard_unit.sv
design/rv32i_cpu.sv
test/rv32i_tb_mem.sv
test/rv32i_cpu_tb.sv

// ==== test/rv32i_cpu_tb.sv ====
module rv32i_cpu_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int TIMEOUT_CYCLES = 2000;
  localparam int MAX_STORES     = 128;

  logic        clk;
  logic        reset;
  logic [31:0] pc;
  logic [31:0] inst;
  logic        mem_we;
  logic [31:0] mem_addr;
  logic [31:0] mem_wdata;
  logic [31:0] mem_rdata;

  // Architectural model, run while the program is built
  logic [31:0] xr [0:31];
  logic [31:0] ram_model [0:255];
  logic [31:0] exp_addr [0:MAX_STORES-1];
  logic [31:0] exp_data [0:MAX_STORES-1];
  string       exp_name [0:MAX_STORES-1];
  int          n_exp;
  int          store_count;
  string       cur_test;
  logic [31:0] gen_pc;
  int          skip_left;  // Instructions the model jumps over
  logic        live;
  logic [31:0] lfsr;

  rv32i_cpu dut_i (
    .clk         (clk),
    .reset       (reset),
    .o_pc        (pc),
    .i_inst      (inst),
    .o_mem_we    (mem_we),
    .o_mem_addr  (mem_addr),
    .o_mem_wdata (mem_wdata),
    .i_mem_rdata (mem_rdata)
  );

  rv32i_tb_mem mem_i (
    .clk     (clk),
    .i_pc    (pc),
    .o_inst  (inst),
    .i_we    (mem_we),
    .i_addr  (mem_addr),
    .i_wdata (mem_wdata),
    .o_rdata (mem_rdata)
  );

  // Galois LFSR, one step per bit taken
  function automatic logic [31:0] next_bits(input int n);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++)
    begin
      val  = {val[30:0], lfsr[0]};
      lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'h8020_0003 : lfsr >> 1;
    end
    return val;
  endfunction

  function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic sub,
                                          input logic [31:0] a, input logic [31:0] b);
    case (f3)
      3'b000:  return sub ? a - b : a + b;
      3'b001:  return a << b[4:0];
      3'b100:  return a ^ b;
      3'b110:  return a | b;
      default: return a & b;
    endcase
  endfunction

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("tests failed");
    $fatal(1, "simulation stopped");
  endtask

  task automatic report_mismatch(input string name, input logic [63:0] expected,
                                 input logic [63:0] actual);
    stop_run($sformatf("MISMATCH %s: expected %h, actual %h", name, expected, actual));
  endtask

  task automatic put(input logic [31:0] word);
    mem_i.rom[gen_pc[9:2]] = word;
    gen_pc = gen_pc + 32'd4;
    live   = (skip_left == 0);
    if (!live)
      skip_left--;
  endtask

  task automatic write_reg(input logic [4:0] rd, input logic [31:0] val);
    if (rd != 5'd0)
      xr[rd] = val;
  endtask

  task automatic alu_rr(input logic [2:0] f3, input logic sub, input logic [4:0] rd,
                        input logic [4:0] rs1, input logic [4:0] rs2);
    put({1'b0, sub, 5'b0, rs2, rs1, f3, rd, 7'b0110011});
    if (live)
      write_reg(rd, alu_ref(f3, sub, xr[rs1], xr[rs2]));
  endtask

  task automatic alu_ri(input logic [2:0] f3, input logic [4:0] rd, input logic [4:0] rs1,
                        input logic [11:0] imm);
    put({imm, rs1, f3, rd, 7'b0010011});
    if (live)
      write_reg(rd, alu_ref(f3, 1'b0, xr[rs1], {{20{imm[11]}}, imm}));
  endtask

  // sw rs2, offs(x0)
  task automatic store(input logic [4:0] rs2, input logic [11:0] offs);
    put({offs[11:5], rs2, 5'd0, 3'b010, offs[4:0], 7'b0100011});
    if (live)
    begin
      ram_model[offs[9:2]] = xr[rs2];
      exp_addr[n_exp]      = {20'b0, offs};
      exp_data[n_exp]      = xr[rs2];
      exp_name[n_exp]      = cur_test;
      n_exp++;
    end
  endtask

  task automatic load(input logic [4:0] rd, input logic [11:0] offs);
    put({offs, 5'd0, 3'b010, rd, 7'b0000011});
    if (live)
      write_reg(rd, ram_model[offs[9:2]]);
  endtask

  // Offset 12 skips exactly the two instructions a redirect cancels
  task automatic branch(input logic [2:0] f3, input logic [4:0] rs1, input logic [4:0] rs2);
    logic taken;
    case (f3)
      3'b000:  taken = (xr[rs1] == xr[rs2]);
      3'b001:  taken = (xr[rs1] != xr[rs2]);
      3'b100:  taken = ($signed(xr[rs1]) < $signed(xr[rs2]));
      default: taken = ($signed(xr[rs1]) >= $signed(xr[rs2]));
    endcase
    put({1'b0, 6'b0, rs2, rs1, f3, 4'b0110, 1'b0, 7'b1100011});
    if (live && taken)
      skip_left = 2;
  endtask

  task automatic jump(input logic [4:0] rd, input logic [11:0] offs);
    logic [31:0] link;
    link = gen_pc + 32'd4;
    put({1'b0, offs[10:1], offs[11], 8'b0, rd, 7'b1101111});
    if (live)
    begin
      write_reg(rd, link);
      if (offs != 12'd0)
        skip_left = int'(offs[11:2]) - 1;
    end
  endtask

  task automatic build_program();
    logic [4:0] rd;
    logic [2:0] pick;
    lfsr      = 32'hb7e9_4309;
    gen_pc    = '0;
    skip_left = 0;
    n_exp     = 0;
    for (int i = 0; i < 256; i++)
      mem_i.rom[i] = '0;
    for (int i = 0; i < 256; i++)
      ram_model[i] = 32'h9e37_79b9 * (i + 1);  // Same fill as the data RAM
    for (int i = 0; i < 32; i++)
      xr[i] = '0;

    // Each op reads the last one or two results
    cur_test = "alu_chain";
    alu_ri(3'b000, 5'd1, 5'd0, 12'(next_bits(12)));
    alu_ri(3'b000, 5'd2, 5'd1, 12'(next_bits(12)));
    for (int i = 3; i < 16; i++)
    begin
      rd   = 5'(i);
      pick = 3'(next_bits(3));
      case (pick)
        3'd0: alu_rr(3'b000, 1'b0, rd, rd - 5'd1, rd - 5'd2);
        3'd1: alu_rr(3'b000, 1'b1, rd, rd - 5'd1, rd - 5'd3);  // Decode bypass distance
        3'd2: alu_rr(3'b111, 1'b0, rd, rd - 5'd1, rd - 5'd2);
        3'd3: alu_rr(3'b110, 1'b0, rd, rd - 5'd2, rd - 5'd1);
        3'd4: alu_rr(3'b100, 1'b0, rd, rd - 5'd1, rd - 5'd2);
        3'd5: alu_ri(3'b100, rd, rd - 5'd1, 12'(next_bits(12)));
        3'd6: alu_ri(3'b110, rd, rd - 5'd1, 12'(next_bits(12)));
        default: alu_ri(3'b111, rd, rd - 5'd1, 12'(next_bits(12)));
      endcase
      if (i[0])
        store(rd, {5'b00100, rd, 2'b00});  // Store data from EX/MEM
    end
    for (int i = 1; i < 16; i++)
      store(5'(i), {5'b00100, 5'(i), 2'b00});

    cur_test = "load_use";
    load(5'd16, 12'h10c);
    alu_rr(3'b000, 1'b0, 5'd17, 5'd16, 5'd5);
    store(5'd17, 12'h180);
    load(5'd18, 12'h114);
    store(5'd18, 12'h184);

    cur_test = "branch";
    alu_ri(3'b000, 5'd10, 5'd0, 12'd0);
    alu_ri(3'b000, 5'd24, 5'd0, {1'b1, 11'(next_bits(11))});  // Negative
    alu_ri(3'b000, 5'd25, 5'd0, {1'b0, 11'(next_bits(11))});
    alu_ri(3'b000, 5'd26, 5'd24, 12'd0);
    for (int b = 0; b < 8; b++)
    begin
      case (b)
        0: branch(3'b000, 5'd24, 5'd26);
        1: branch(3'b000, 5'd24, 5'd25);
        2: branch(3'b001, 5'd24, 5'd25);
        3: branch(3'b001, 5'd24, 5'd26);
        4: branch(3'b100, 5'd24, 5'd25);
        5: branch(3'b100, 5'd25, 5'd24);
        6: branch(3'b101, 5'd25, 5'd24);
        default: branch(3'b101, 5'd24, 5'd25);
      endcase
      alu_ri(3'b000, 5'd10, 5'd10, 12'd1);
      store(5'd10, 12'h200 + 12'(8 * b));  // Fall-through marker
      store(5'd10, 12'h204 + 12'(8 * b));  // Target marker
    end

    cur_test = "jal";
    jump(5'd27, 12'd12);
    alu_ri(3'b000, 5'd10, 5'd10, 12'd1);
    store(5'd10, 12'h280);
    store(5'd27, 12'h284);

    cur_test = "shift_sub";
    alu_ri(3'b001, 5'd28, 5'd25, {7'b0, 5'(next_bits(5))});
    alu_ri(3'b000, 5'd29, 5'd0, {7'b0, 5'(next_bits(5))});
    alu_rr(3'b001, 1'b0, 5'd30, 5'd24, 5'd29);
    alu_rr(3'b000, 1'b1, 5'd31, 5'd24, 5'd25);
    for (int r = 28; r < 32; r++)
      store(5'(r), 12'h300 + 12'(4 * (r - 28)));
    jump(5'd0, 12'd0);  // Park here
  endtask

  always @(posedge clk or posedge reset)
  begin
    if (reset)
      store_count <= 0;
    else if (mem_we)
      store_count <= store_count + 1;
  end

  // Outputs settle after the rising edge, so check on the falling one
  a_reset_clear: assert property (@(negedge clk) reset |-> (pc == '0 && !mem_we))
    else report_mismatch("reset", 64'd0, {pc, 31'd0, mem_we});

  a_store_extra: assert property (@(negedge clk) disable iff (reset)
    mem_we |-> store_count < n_exp)
    else stop_run($sformatf("unexpected store to %h after all %0d expected stores",
                            mem_addr, n_exp));

  a_store_value: assert property (@(negedge clk) disable iff (reset)
    (mem_we && store_count < n_exp) |->
      (mem_addr == exp_addr[store_count] && mem_wdata == exp_data[store_count]))
    else report_mismatch(exp_name[store_count],
                         {exp_addr[store_count], exp_data[store_count]},
                         {mem_addr, mem_wdata});

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  initial
  begin
    int cycles;
    reset = 1'b1;
    build_program();
    repeat (10) @(posedge clk);
    @(negedge clk);
    reset  = 1'b0;
    cycles = 0;
    while (store_count < n_exp && cycles < TIMEOUT_CYCLES)
    begin
      @(negedge clk);
      cycles++;
    end
    if (store_count < n_exp)
      stop_run($sformatf("timed out with %0d of %0d stores seen", store_count, n_exp));
    else
    begin
      $display("all tests passed");
      $finish;
    end
  end

endmodule

// ==== test/rv32i_tb_mem.sv ====
module rv32i_tb_mem (
  input  logic        clk,
  input  logic [31:0] i_pc,
  output logic [31:0] o_inst,
  input  logic        i_we,
  input  logic [31:0] i_addr,
  input  logic [31:0] i_wdata,
  output logic [31:0] o_rdata
);
  timeunit 1ns;
  timeprecision 1ps;

  logic [31:0] rom [0:255];  // Written by the testbench program builder
  logic [31:0] ram [0:255];

  // Word index times an odd constant, so every address bit shows up
  initial
  begin
    for (int i = 0; i < 256; i++)
      ram[i] <= 32'h9e37_79b9 * (i + 1);
  end

  always @(posedge clk)
  begin
    if (i_we)
      ram[i_addr[9:2]] <= i_wdata;
  end

  assign o_inst  = rom[i_pc[9:2]];
  assign o_rdata = ram[i_addr[9:2]];  // Combinational read

endmodule
